// ==== design/vic_macros.svh ====
// VIC I/O block widths and timing constants
// Shared by the decoder, coin circuit and port blocks

`ifndef VIC_MACROS_SVH
`define VIC_MACROS_SVH

// ------------------------------
// Bus widths
// ------------------------------

// CPU data byte
`define VIC_DATA_W 8

// Z80 address bus
`define VIC_ADDR_W 16

// Input and output port count
`define VIC_PORTS 4

// ------------------------------
// Timer and coin circuit
// ------------------------------

// Clock count at which the periodic timer flips
`define VIC_TIMER_PERIOD 19500

// Coin start counter, all ones gives the reset pulse length
`define VIC_COIN_START_W 6

// Coin latch counter, all ones is the long style
`define VIC_COIN_LATCH_W 10

// Latch length for short style games
`define VIC_COIN_SHORT 15

`endif

// ==== design/vic_pkg.sv ====
// VIC I/O shared types
// Game selection, bus cycle kinds and per-game configuration

`default_nettype none

package vic_pkg;

	// ------------------------------
	// Supported games
	// ------------------------------
	typedef enum logic [2:0] {
		GAME_HEADON      = 3'd0,
		GAME_DIGGER      = 3'd1,
		GAME_SPACEATTACK = 3'd2,
		GAME_CARNIVAL    = 3'd3,
		GAME_PULSAR      = 3'd4
	} game_t;

	// ------------------------------
	// Bus cycle kinds
	// ------------------------------
	// Derived from mreq_n, iorq_n, rd_n and wr_n
	typedef enum logic [2:0] {
		CYC_IDLE = 3'd0,
		CYC_MEMR = 3'd1,
		CYC_MEMW = 3'd2,
		CYC_IN   = 3'd3,
		CYC_OUT  = 3'd4
	} bus_cycle_t;

	// ------------------------------
	// Per-game board options
	// ------------------------------
	typedef struct packed {
		// Binary port decode on address bits 1:0
		logic alt_input;
		// Short coin latch length
		logic short_latch;
	} game_cfg_t;

endpackage

`default_nettype wire

// ==== design/io_bus_if.sv ====
// Decoded CPU bus information
// Driven by the decoder, read by the port and coin blocks

`default_nettype none

`include "vic_macros.svh"

interface io_bus_if;
	import vic_pkg::*;

	// Registered cycle kind
	bus_cycle_t cycle;
	// Input port selects, bit 0 is port 1
	logic [`VIC_PORTS-1:0] in_sel;
	// One cycle load strobes per output port
	logic [`VIC_PORTS-1:0] out_load;
	// Registered CPU write data
	logic [`VIC_DATA_W-1:0] wdata;

	modport decoder (
		output cycle,
		output in_sel,
		output out_load,
		output wdata
	);

	modport input_side (
		input cycle,
		input in_sel
	);

	modport output_side (
		input out_load,
		input wdata
	);

	// Coin latch counts on port 4 reads
	modport coin_side (
		input in_sel
	);

endinterface

`default_nettype wire

// ==== design/io_decode.sv ====
// CPU bus decoder
// Classifies Z80 strobes, decodes port selects and output-select edges

`default_nettype none

`include "vic_macros.svh"

module io_decode (
	input  logic                   clk,
	input  logic                   reset,
	input  vic_pkg::game_cfg_t     cfg,
	input  logic                   mreq_n,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic [`VIC_ADDR_W-1:0] cpu_addr,
	input  logic [`VIC_DATA_W-1:0] cpu_data_out,
	io_bus_if.decoder              bus
);
	import vic_pkg::*;

	// Active high strobe decode
	logic memr;
	logic memw;
	logic in_cyc;
	logic out_cyc;
	bus_cycle_t cycle_next;
	logic [`VIC_PORTS-1:0] in_next;
	logic [`VIC_PORTS-1:0] out_next;
	// Output selects seen at the previous edge
	logic [`VIC_PORTS-1:0] out_sel_q;

	assign memr    = ~(rd_n | mreq_n);
	assign memw    = ~(wr_n | mreq_n);
	assign in_cyc  = ~(rd_n | iorq_n);
	assign out_cyc = ~(wr_n | iorq_n);

	// ------------------------------
	// Cycle classification
	// ------------------------------
	// I/O strobes take priority over memory
	always_comb
	begin
		if (in_cyc)
			cycle_next = CYC_IN;
		else if (out_cyc)
			cycle_next = CYC_OUT;
		else if (memr)
			cycle_next = CYC_MEMR;
		else if (memw)
			cycle_next = CYC_MEMW;
		else
			cycle_next = CYC_IDLE;
	end

	// ------------------------------
	// Port selects
	// ------------------------------
	always_comb
	begin
		for (int i = 0; i < `VIC_PORTS; i++)
		begin
			// Standard boards use one address line per port
			// Alternate boards use a 2 bit port number
			if (cfg.alt_input)
				in_next[i] = in_cyc && (cpu_addr[1:0] == 2'(i));
			else
				in_next[i] = in_cyc && cpu_addr[i];
			// Outputs are always one-hot
			out_next[i] = out_cyc && cpu_addr[i];
		end
	end

	// Registered bus view, out_load fires on the first cycle of a select
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bus.cycle    <= CYC_IDLE;
			bus.in_sel   <= '0;
			bus.out_load <= '0;
			out_sel_q    <= '0;
		end
		else
		begin
			bus.cycle    <= cycle_next;
			bus.in_sel   <= in_next;
			bus.out_load <= out_next & ~out_sel_q;
			out_sel_q    <= out_next;
		end
	end

	// Write data lines up with out_load
	always_ff @(posedge clk)
	begin
		bus.wdata <= cpu_data_out;
	end

endmodule

`default_nettype wire

// ==== design/coin_timer.sv ====
// Periodic timer and coin circuit
// Coin edge pulses CPU reset, then a latch counts down on port 4 reads

`default_nettype none

`include "vic_macros.svh"

module coin_timer (
	input  logic               clk,
	input  logic               reset,
	input  vic_pkg::game_cfg_t cfg,
	input  logic               coin,
	io_bus_if.coin_side        bus,
	output logic               cpu_reset,
	output logic               timer_status,
	output logic               coin_latch_active
);

	localparam int TIMER_W = $clog2(`VIC_TIMER_PERIOD + 1);
	localparam int START_W = `VIC_COIN_START_W;
	localparam int LATCH_W = `VIC_COIN_LATCH_W;

	logic [TIMER_W-1:0] timer_count;
	logic               coin_last;
	logic               coin_inserted;
	logic [START_W-1:0] coin_start;
	logic [LATCH_W-1:0] coin_latch;
	logic [LATCH_W-1:0] latch_max;
	logic               port4_rd;

	// Port 4 read in progress
	assign port4_rd = bus.in_sel[3];

	// ------------------------------
	// Periodic timer
	// ------------------------------
	// Flips every period plus one clocks
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			timer_count  <= '0;
			timer_status <= 1'b1;
		end
		else if (timer_count == TIMER_W'(`VIC_TIMER_PERIOD))
		begin
			timer_count  <= '0;
			timer_status <= ~timer_status;
		end
		else
		begin
			timer_count <= timer_count + 1'b1;
		end
	end

	// ------------------------------
	// Coin start and latch
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			coin_last     <= coin;
			coin_inserted <= 1'b0;
			coin_start    <= '0;
			coin_latch    <= '0;
			// Latch length picked once per game
			latch_max     <= cfg.short_latch ? LATCH_W'(`VIC_COIN_SHORT) : '1;
		end
		else
		begin
			coin_last <= coin;

			// Rising coin edge restarts the CPU
			if (coin && !coin_last)
			begin
				coin_inserted <= 1'b1;
				coin_start    <= '1;
			end
			else if (coin_start != '0)
			begin
				coin_start <= coin_start - 1'b1;
			end

			// First port 4 read after the pulse arms the latch
			if (port4_rd)
			begin
				if (coin_inserted && coin_start == '0)
				begin
					coin_latch    <= latch_max;
					coin_inserted <= 1'b0;
				end
				else if (coin_latch != '0)
				begin
					coin_latch <= coin_latch - 1'b1;
				end
			end
		end
	end

	// CPU held in reset during board reset and the coin pulse
	assign cpu_reset         = reset || (coin_start != '0);
	assign coin_latch_active = (coin_latch != '0);

endmodule

`default_nettype wire

// ==== design/input_select.sv ====
// Input port block
// Registers player inputs, overlays game status bits, drives CPU read data

`default_nettype none

`include "vic_macros.svh"

module input_select (
	input  logic                   clk,
	input  logic                   reset,
	input  vic_pkg::game_t         game_mode,
	input  logic [`VIC_DATA_W-1:0] in_p1,
	input  logic [`VIC_DATA_W-1:0] in_p2,
	input  logic [`VIC_DATA_W-1:0] in_p3,
	input  logic [`VIC_DATA_W-1:0] in_p4,
	input  logic                   hblank,
	input  logic                   vblank,
	input  logic                   vcnt_64,
	input  logic                   timer_status,
	input  logic                   coin_latch_active,
	io_bus_if.input_side           bus,
	output logic [`VIC_DATA_W-1:0] cpu_data_in
);
	import vic_pkg::*;

	// Port data as the CPU sees it, index 0 is port 1
	logic [`VIC_DATA_W-1:0] port_data [`VIC_PORTS];
	// High outside both blanking periods
	logic                   blank_n;

	assign blank_n = ~(hblank | vblank);

	// ------------------------------
	// Player data and status overlay
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `VIC_PORTS; i++)
				port_data[i] <= '1;
		end
		else
		begin
			port_data[0] <= in_p1;
			port_data[1] <= in_p2;
			port_data[2] <= in_p3;
			port_data[3] <= in_p4;

			// Later assignments replace single player bits
			case (game_mode)
				GAME_HEADON:
				begin
					port_data[3][0] <= vcnt_64;
					port_data[3][7] <= ~coin_latch_active;
				end
				GAME_DIGGER:
				begin
					port_data[3][0] <= blank_n;
					port_data[3][7] <= coin_latch_active;
				end
				GAME_SPACEATTACK:
				begin
					port_data[3][0] <= timer_status;
					port_data[3][7] <= ~coin_latch_active;
				end
				// Alternate style boards use bit 3 on ports 2 to 4
				GAME_CARNIVAL, GAME_PULSAR:
				begin
					port_data[1][3] <= blank_n;
					port_data[2][3] <= timer_status;
					port_data[3][3] <= coin_latch_active;
				end
				default:
				begin
				end
			endcase
		end
	end

	// ------------------------------
	// CPU read mux
	// ------------------------------
	// Lowest numbered port wins, idle bus reads all ones
	always_comb
	begin
		cpu_data_in = '1;
		if (bus.cycle == CYC_IN)
		begin
			for (int i = `VIC_PORTS - 1; i >= 0; i--)
			begin
				if (bus.in_sel[i])
					cpu_data_in = port_data[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/output_latch.sv ====
// Output port registers
// Four byte latches loaded on output-select edges

`default_nettype none

`include "vic_macros.svh"

module output_latch (
	input  logic                   clk,
	input  logic                   reset,
	io_bus_if.output_side          bus,
	output logic [`VIC_DATA_W-1:0] out_p1,
	output logic [`VIC_DATA_W-1:0] out_p2,
	output logic [`VIC_DATA_W-1:0] out_p3,
	output logic [`VIC_DATA_W-1:0] out_p4
);

	// Index 0 is port 1
	logic [`VIC_DATA_W-1:0] port_q [`VIC_PORTS];

	// Idle state of the board outputs is all ones
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `VIC_PORTS; i++)
				port_q[i] <= '1;
		end
		else
		begin
			// Each port loads only on its own strobe
			for (int i = 0; i < `VIC_PORTS; i++)
			begin
				if (bus.out_load[i])
					port_q[i] <= bus.wdata;
			end
		end
	end

	assign out_p1 = port_q[0];
	assign out_p2 = port_q[1];
	assign out_p3 = port_q[2];
	assign out_p4 = port_q[3];

endmodule

`default_nettype wire

// ==== design/vic_io.sv ====
// VIC arcade board I/O and game logic
// Port decode, status overlay, output latches, timer and coin circuit

`default_nettype none

`include "vic_macros.svh"

module vic_io (
	input  logic                   clk,
	input  logic                   reset,
	input  vic_pkg::game_t         game_mode,
	input  logic                   mreq_n,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic [`VIC_ADDR_W-1:0] cpu_addr,
	input  logic [`VIC_DATA_W-1:0] cpu_data_out,
	input  logic [`VIC_DATA_W-1:0] in_p1,
	input  logic [`VIC_DATA_W-1:0] in_p2,
	input  logic [`VIC_DATA_W-1:0] in_p3,
	input  logic [`VIC_DATA_W-1:0] in_p4,
	input  logic                   hblank,
	input  logic                   vblank,
	input  logic                   vcnt_64,
	input  logic                   coin,
	output logic [`VIC_DATA_W-1:0] cpu_data_in,
	output logic                   cpu_reset,
	output logic [`VIC_DATA_W-1:0] out_p1,
	output logic [`VIC_DATA_W-1:0] out_p2,
	output logic [`VIC_DATA_W-1:0] out_p3,
	output logic [`VIC_DATA_W-1:0] out_p4
);
	import vic_pkg::*;

	game_cfg_t cfg;
	logic      timer_status;
	logic      coin_latch_active;

	io_bus_if bus ();

	// ------------------------------
	// Game configuration lookup
	// ------------------------------
	// Carnival and Pulsar decode ports in binary, Pulsar has the short latch
	always_comb
	begin
		cfg = '0;
		case (game_mode)
			GAME_CARNIVAL:
				cfg.alt_input = 1'b1;
			GAME_PULSAR:
			begin
				cfg.alt_input   = 1'b1;
				cfg.short_latch = 1'b1;
			end
			default:
				cfg = '0;
		endcase
	end

	io_decode u_decode (
		.clk          (clk),
		.reset        (reset),
		.cfg          (cfg),
		.mreq_n       (mreq_n),
		.iorq_n       (iorq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.cpu_addr     (cpu_addr),
		.cpu_data_out (cpu_data_out),
		.bus          (bus.decoder)
	);

	coin_timer u_coin (
		.clk               (clk),
		.reset             (reset),
		.cfg               (cfg),
		.coin              (coin),
		.bus               (bus.coin_side),
		.cpu_reset         (cpu_reset),
		.timer_status      (timer_status),
		.coin_latch_active (coin_latch_active)
	);

	input_select u_inputs (
		.clk               (clk),
		.reset             (reset),
		.game_mode         (game_mode),
		.in_p1             (in_p1),
		.in_p2             (in_p2),
		.in_p3             (in_p3),
		.in_p4             (in_p4),
		.hblank            (hblank),
		.vblank            (vblank),
		.vcnt_64           (vcnt_64),
		.timer_status      (timer_status),
		.coin_latch_active (coin_latch_active),
		.bus               (bus.input_side),
		.cpu_data_in       (cpu_data_in)
	);

	output_latch u_outputs (
		.clk    (clk),
		.reset  (reset),
		.bus    (bus.output_side),
		.out_p1 (out_p1),
		.out_p2 (out_p2),
		.out_p3 (out_p3),
		.out_p4 (out_p4)
	);

endmodule

`default_nettype wire

// ==== tb/vic_io_checker.sv ====
// Bound assertions on the VIC I/O block
// CPU reset rules for board reset and the coin start pulse

`default_nettype none

module vic_io_checker (
	input logic clk,
	input logic reset,
	input logic coin,
	input logic cpu_reset
);

	// Assertion failures so far
	int fail_count = 0;

	// ------------------------------
	// Board reset
	// ------------------------------
	// CPU is held whenever the board is in reset
	reset_holds_cpu: assert property (@(posedge clk) reset |-> cpu_reset)
	else
	begin
		$error("cpu_reset low while reset is high");
		fail_count++;
	end

	// ------------------------------
	// Coin start pulse
	// ------------------------------
	// Pulse starts on the clock after the coin edge
	coin_starts_pulse: assert property (@(posedge clk) disable iff (reset)
		$rose(coin) |=> cpu_reset)
	else
	begin
		$error("cpu_reset did not follow the coin edge");
		fail_count++;
	end

	// Still held well into the pulse
	coin_pulse_holds: assert property (@(posedge clk) disable iff (reset)
		$rose(coin) |-> ##30 cpu_reset)
	else
	begin
		$error("cpu_reset pulse ended too early");
		fail_count++;
	end

endmodule

bind vic_io vic_io_checker u_checker (
	.clk       (clk),
	.reset     (reset),
	.coin      (coin),
	.cpu_reset (cpu_reset)
);

`default_nettype wire

// ==== tb/tb_vic_io.sv ====
// Testbench for the VIC I/O block
// Directed tests for ports, status overlay, timer and coin circuit

`default_nettype none

`include "vic_macros.svh"

module tb_vic_io;
	import vic_pkg::*;

	// Rough lengths of the tests in clocks
	localparam int TIMER_TEST_CYCLES = `VIC_TIMER_PERIOD + 100;
	localparam int COIN_TEST_CYCLES  = 1400;
	localparam int SHORT_TEST_CYCLES = 6000;
	localparam int TIMEOUT_CYCLES    =
		2 * (TIMER_TEST_CYCLES + 2 * COIN_TEST_CYCLES + SHORT_TEST_CYCLES);

	logic                   clk;
	logic                   reset;
	game_t                  game_mode;
	logic                   mreq_n;
	logic                   iorq_n;
	logic                   rd_n;
	logic                   wr_n;
	logic [`VIC_ADDR_W-1:0] cpu_addr;
	logic [`VIC_DATA_W-1:0] cpu_data_out;
	logic [`VIC_DATA_W-1:0] in_p1;
	logic [`VIC_DATA_W-1:0] in_p2;
	logic [`VIC_DATA_W-1:0] in_p3;
	logic [`VIC_DATA_W-1:0] in_p4;
	logic                   hblank;
	logic                   vblank;
	logic                   vcnt_64;
	logic                   coin;
	logic [`VIC_DATA_W-1:0] cpu_data_in;
	logic                   cpu_reset;
	logic [`VIC_DATA_W-1:0] out_p1;
	logic [`VIC_DATA_W-1:0] out_p2;
	logic [`VIC_DATA_W-1:0] out_p3;
	logic [`VIC_DATA_W-1:0] out_p4;

	integer seed;
	int     errors;
	int     test_start;
	int     tests;
	int     cycle_count;

	vic_io DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Watchdog, counts every clock of the run
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Something failed");
		$finish;
	end

	// ------------------------------
	// Checks
	// ------------------------------
	task automatic compare_byte(input string name, input logic [`VIC_DATA_W-1:0] got,
		input logic [`VIC_DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("error at t=%0t: %s", $time, msg);
		errors++;
	endtask

	task automatic begin_test();
		test_start = errors;
		tests++;
	endtask

	task automatic end_test(input string name);
		if (errors == test_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - test_start);
	endtask

	// Player bits replaced by status bits, cleared in the mask
	function automatic logic [`VIC_DATA_W-1:0] overlay_mask(input game_t game, input int port);
		logic [`VIC_DATA_W-1:0] mask;
		mask = '1;
		if (game == GAME_CARNIVAL || game == GAME_PULSAR)
		begin
			if (port >= 1)
				mask[3] = 1'b0;
		end
		else if (port == 3)
		begin
			mask[0] = 1'b0;
			mask[7] = 1'b0;
		end
		return mask;
	endfunction

	function automatic logic [`VIC_DATA_W-1:0] out_port(input int port);
		case (port)
			0:       return out_p1;
			1:       return out_p2;
			2:       return out_p3;
			default: return out_p4;
		endcase
	endfunction

	// ------------------------------
	// Bus tasks
	// ------------------------------
	// Eight clocks of reset with the game selected, bus idle
	task automatic apply_reset(input game_t game);
		@(posedge clk);
		game_mode <= game;
		reset     <= 1'b1;
		mreq_n    <= 1'b1;
		iorq_n    <= 1'b1;
		rd_n      <= 1'b1;
		wr_n      <= 1'b1;
		coin      <= 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
	endtask

	// Output cycle held for three clocks
	task automatic io_write(input logic [`VIC_ADDR_W-1:0] addr,
		input logic [`VIC_DATA_W-1:0] data);
		@(posedge clk);
		cpu_addr     <= addr;
		cpu_data_out <= data;
		iorq_n       <= 1'b0;
		wr_n         <= 1'b0;
		repeat (3) @(posedge clk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
	endtask

	// Input cycle begins, returns once read data is valid
	task automatic start_read(input logic [`VIC_ADDR_W-1:0] addr);
		@(posedge clk);
		cpu_addr <= addr;
		iorq_n   <= 1'b0;
		rd_n     <= 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic end_read();
		@(posedge clk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		@(negedge clk);
	endtask

	task automatic read_port(input logic [`VIC_ADDR_W-1:0] addr,
		output logic [`VIC_DATA_W-1:0] data);
		start_read(addr);
		data = cpu_data_in;
		end_read();
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic test_output_ports();
		logic [`VIC_DATA_W-1:0] exp_port [`VIC_PORTS];
		logic [`VIC_DATA_W-1:0] wr_byte;
		begin_test();
		apply_reset(GAME_HEADON);
		for (int i = 0; i < `VIC_PORTS; i++)
		begin
			exp_port[i] = '1;
			compare_byte($sformatf("out_p%0d", i + 1), out_port(i), exp_port[i]);
		end
		// One-hot port address, only that port changes
		for (int i = 0; i < `VIC_PORTS; i++)
		begin
			wr_byte = `VIC_DATA_W'($random(seed));
			exp_port[i] = wr_byte;
			io_write(`VIC_ADDR_W'(1 << i), wr_byte);
			for (int j = 0; j < `VIC_PORTS; j++)
				compare_byte($sformatf("out_p%0d", j + 1), out_port(j), exp_port[j]);
		end
		end_test("output ports");
	endtask

	task automatic test_input_decode(input game_t game, input string name);
		logic [`VIC_DATA_W-1:0] player [`VIC_PORTS];
		logic [`VIC_DATA_W-1:0] got;
		logic [`VIC_DATA_W-1:0] mask;
		logic [`VIC_ADDR_W-1:0] addr;
		logic                   alt;
		begin_test();
		apply_reset(game);
		alt = (game == GAME_CARNIVAL || game == GAME_PULSAR);
		for (int i = 0; i < `VIC_PORTS; i++)
			player[i] = `VIC_DATA_W'($random(seed));
		@(posedge clk);
		in_p1 <= player[0];
		in_p2 <= player[1];
		in_p3 <= player[2];
		in_p4 <= player[3];
		@(negedge clk);
		// No input cycle, bus floats high
		compare_byte("cpu_data_in", cpu_data_in, '1);
		for (int i = 0; i < `VIC_PORTS; i++)
		begin
			addr = alt ? `VIC_ADDR_W'(i) : `VIC_ADDR_W'(1 << i);
			read_port(addr, got);
			mask = overlay_mask(game, i);
			compare_byte($sformatf("cpu_data_in port %0d", i + 1), got & mask,
				player[i] & mask);
		end
		end_test(name);
	endtask

	task automatic test_status_overlay();
		logic [`VIC_DATA_W-1:0] got;
		begin_test();
		// Digger blank bit, high outside blanking
		apply_reset(GAME_DIGGER);
		@(posedge clk);
		hblank <= 1'b0;
		vblank <= 1'b0;
		read_port(16'h0008, got);
		compare_bit("cpu_data_in[0]", got[0], 1'b1);
		@(posedge clk);
		hblank <= 1'b1;
		read_port(16'h0008, got);
		compare_bit("cpu_data_in[0]", got[0], 1'b0);
		@(posedge clk);
		hblank <= 1'b0;
		vblank <= 1'b1;
		read_port(16'h0008, got);
		compare_bit("cpu_data_in[0]", got[0], 1'b0);
		@(posedge clk);
		vblank <= 1'b0;
		// Head On vertical count bit
		apply_reset(GAME_HEADON);
		@(posedge clk);
		vcnt_64 <= 1'b0;
		read_port(16'h0008, got);
		compare_bit("cpu_data_in[0]", got[0], 1'b0);
		@(posedge clk);
		vcnt_64 <= 1'b1;
		read_port(16'h0008, got);
		compare_bit("cpu_data_in[0]", got[0], 1'b1);
		end_test("status overlay");
	endtask

	task automatic test_timer();
		int start;
		int elapsed;
		begin_test();
		apply_reset(GAME_SPACEATTACK);
		start = cycle_count;
		start_read(16'h0008);
		compare_bit("cpu_data_in[0]", cpu_data_in[0], 1'b1);
		while (cpu_data_in[0] === 1'b1 && cycle_count - start <= `VIC_TIMER_PERIOD + 10)
			@(negedge clk);
		elapsed = cycle_count - start;
		if (cpu_data_in[0] === 1'b1)
			report_error("timer bit did not change within the timer period");
		else if (elapsed < `VIC_TIMER_PERIOD - 10)
			report_error($sformatf("timer bit changed after only %0d cycles", elapsed));
		end_read();
		end_test("timer");
	endtask

	// Coin pulse, then latch seen on port 4 bit 3 during a held read
	task automatic test_coin(input game_t game, input string name, input int active_cycles,
		input int clear_cycles);
		int width;
		int wait_cycles;
		begin_test();
		apply_reset(game);
		compare_bit("cpu_reset", cpu_reset, 1'b0);
		@(posedge clk);
		coin <= 1'b1;
		wait_cycles = 0;
		while (cpu_reset !== 1'b1 && wait_cycles < 10)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		if (cpu_reset !== 1'b1)
			report_error("cpu_reset did not rise after the coin edge");
		width = 0;
		while (cpu_reset === 1'b1 && width < 100)
		begin
			@(negedge clk);
			width++;
		end
		if (width < 60 || width > 66)
			report_error($sformatf("cpu_reset pulse lasted %0d cycles", width));
		@(posedge clk);
		coin <= 1'b0;
		start_read(16'h0003);
		// Latch arms on the first selected clock and reaches the overlay one clock later
		@(negedge clk);
		compare_bit("cpu_data_in[3]", cpu_data_in[3], 1'b1);
		repeat (active_cycles) @(negedge clk);
		compare_bit("cpu_data_in[3]", cpu_data_in[3], 1'b1);
		repeat (clear_cycles - active_cycles) @(negedge clk);
		compare_bit("cpu_data_in[3]", cpu_data_in[3], 1'b0);
		end_read();
		end_test(name);
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		seed         = 32'hda34;
		errors       = 0;
		test_start   = 0;
		tests        = 0;
		reset        = 1'b1;
		game_mode    = GAME_HEADON;
		mreq_n       = 1'b1;
		iorq_n       = 1'b1;
		rd_n         = 1'b1;
		wr_n         = 1'b1;
		cpu_addr     = '0;
		cpu_data_out = '0;
		in_p1        = '1;
		in_p2        = '1;
		in_p3        = '1;
		in_p4        = '1;
		hblank       = 1'b0;
		vblank       = 1'b0;
		vcnt_64      = 1'b0;
		coin         = 1'b0;

		test_output_ports();
		test_input_decode(GAME_HEADON, "input decode standard");
		test_input_decode(GAME_CARNIVAL, "input decode alternate");
		test_status_overlay();
		test_timer();
		test_coin(GAME_CARNIVAL, "coin long latch", 900, 1100);
		test_coin(GAME_PULSAR, "coin short latch", 10, 40);

		$display("summary: %0d tests, %0d errors, %0d assertion failures",
			tests, errors, DUT.u_checker.fail_count);
		if (errors == 0 && DUT.u_checker.fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/vic_pkg.sv
design/io_bus_if.sv
design/io_decode.sv
design/coin_timer.sv
design/input_select.sv
design/output_latch.sv
design/vic_io.sv
tb/vic_io_checker.sv
tb/tb_vic_io.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_vic_io
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
